// File: design/cache_cfg.svh
// cache front end configuration
// address, line and index widths and the region nibbles

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_ADDR_W 32
`define CACHE_LINE_W 128
`define CACHE_IDX_W 4
`define CACHE_OFS_W 4
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_IDX_W - `CACHE_OFS_W)

// top address nibble of each region
`define CACHE_RGN_PERI_A 4'h1
`define CACHE_RGN_PERI_B 4'h2
`define CACHE_RGN_FLASH 4'h3

`endif

// File: design/cache_pkg.sv
// cache front end types
// vector typedefs and state enums shared by the RTL

`include "cache_cfg.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_LINE_W-1:0] line_t;
  typedef logic [63:0]              dword_t;
  typedef logic [31:0]              inst_t;
  typedef logic [`CACHE_TAG_W-1:0]  tag_t;
  typedef logic [`CACHE_IDX_W-1:0]  idx_t;
  // byte count minus one
  typedef logic [2:0]               size_t;

  typedef enum logic [1:0] {CORE_IDLE, CORE_LOOKUP, CORE_FILL} core_state_e;
  typedef enum logic {NC_IDLE, NC_BUSY} nc_state_e;
  typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_DATA} owner_e;
  typedef enum logic [1:0] {GNT_NONE, GNT_DCACHE, GNT_NOCACHE, GNT_ICACHE} grant_e;

endpackage

// File: design/cache_route.sv
// request router
// region decode, uncached path ownership, store invalidate and fence.i

`include "cache_cfg.svh"

module cache_route (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_icache_req,
  input  cache_pkg::addr_t  i_icache_addr,
  output logic              o_icache_ack,
  output cache_pkg::inst_t  o_icache_rdata,
  input  logic              i_dcache_req,
  input  cache_pkg::addr_t  i_dcache_addr,
  input  logic              i_dcache_op,
  input  cache_pkg::size_t  i_dcache_bytes,
  input  cache_pkg::dword_t i_dcache_wdata,
  output logic              o_dcache_ack,
  output cache_pkg::dword_t o_dcache_rdata,
  input  logic              i_fencei_req,
  output logic              o_fencei_ack,
  output logic              o_ic_req,
  output cache_pkg::addr_t  o_ic_addr,
  input  logic              i_ic_ack,
  input  cache_pkg::line_t  i_ic_rdata,
  input  logic              i_ic_busy,
  output logic              o_dc_req,
  output cache_pkg::addr_t  o_dc_addr,
  input  logic              i_dc_ack,
  input  cache_pkg::line_t  i_dc_rdata,
  input  logic              i_dc_busy,
  output logic              o_nc_req,
  output cache_pkg::addr_t  o_nc_addr,
  output logic              o_nc_op,
  output cache_pkg::size_t  o_nc_bytes,
  output cache_pkg::dword_t o_nc_wdata,
  input  logic              i_nc_ack,
  input  cache_pkg::dword_t i_nc_rdata,
  output logic              o_inval,
  output cache_pkg::addr_t  o_inval_addr,
  output logic              o_flush
);

  import cache_pkg::*;

  logic   i_cached, d_cached, f_nc, d_nc, fence_ack_q;
  owner_e owner_q, owner;
  dword_t ic_dword, fetch_dword;

  // main memory and flash are cached, peripherals and holes are not
  assign i_cached = i_icache_addr[31] || (i_icache_addr[31:28] == `CACHE_RGN_FLASH);
  assign d_cached = i_dcache_addr[31] || (i_dcache_addr[31:28] == `CACHE_RGN_FLASH);

  assign o_ic_req  = i_icache_req && i_cached;
  assign o_ic_addr = i_icache_addr;
  assign o_dc_req  = i_dcache_req && d_cached && !i_dcache_op;
  assign o_dc_addr = i_dcache_addr;

  ////////////////////////////////////////////////////////////
  // uncached path, data side wins
  assign f_nc = i_icache_req && !i_cached;
  assign d_nc = i_dcache_req && !(d_cached && !i_dcache_op);

  always_comb begin
    if (owner_q != OWN_NONE) owner = owner_q;
    else if (d_nc) owner = OWN_DATA;
    else if (f_nc) owner = OWN_FETCH;
    else owner = OWN_NONE;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      owner_q <= OWN_NONE;
    end else begin
      owner_q <= i_nc_ack ? OWN_NONE : owner;
    end
  end

  assign o_nc_req   = owner != OWN_NONE;
  assign o_nc_addr  = (owner == OWN_FETCH) ? i_icache_addr : i_dcache_addr;
  assign o_nc_op    = (owner == OWN_DATA) && i_dcache_op;
  assign o_nc_bytes = (owner == OWN_FETCH) ? 3'd3 : i_dcache_bytes;
  assign o_nc_wdata = (owner == OWN_DATA) ? i_dcache_wdata : '0;

  ////////////////////////////////////////////////////////////
  // responses
  assign o_icache_ack = i_ic_ack || (i_nc_ack && owner_q == OWN_FETCH);
  assign o_dcache_ack = i_dc_ack || (i_nc_ack && owner_q == OWN_DATA);

  assign ic_dword    = i_icache_addr[3] ? i_ic_rdata[127:64] : i_ic_rdata[63:0];
  assign fetch_dword = (owner_q == OWN_FETCH) ? i_nc_rdata : ic_dword;
  assign o_icache_rdata = i_icache_addr[2] ? fetch_dword[63:32] : fetch_dword[31:0];

  always_comb begin
    if (owner_q == OWN_DATA) o_dcache_rdata = i_nc_rdata;
    else if (i_dcache_addr[3]) o_dcache_rdata = i_dc_rdata[127:64];
    else o_dcache_rdata = i_dc_rdata[63:0];
  end

  // completed store drops the line in both caches
  assign o_inval      = i_nc_ack && (owner_q == OWN_DATA) && i_dcache_op;
  assign o_inval_addr = i_dcache_addr;

  ////////////////////////////////////////////////////////////
  // fence.i, flush once both cores are idle, ack next cycle
  assign o_flush = i_fencei_req && !fence_ack_q && !i_ic_busy && !i_dc_busy;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fence_ack_q <= 1'b0;
    end else begin
      fence_ack_q <= o_flush;
    end
  end

  assign o_fencei_ack = fence_ack_q;

  a_nc_owner: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_nc_ack |-> owner_q != OWN_NONE);

endmodule

// File: design/cache_core.sv
// direct-mapped read cache
// lookup, line fill over the memory bus, invalidate port and flush

`include "cache_cfg.svh"

module cache_core (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_req,
  input  cache_pkg::addr_t i_addr,
  output logic             o_ack,
  output cache_pkg::line_t o_rdata,
  output logic             o_busy,
  input  logic             i_inval,
  input  cache_pkg::addr_t i_inval_addr,
  input  logic             i_flush,
  output logic             o_bus_req,
  output cache_pkg::addr_t o_bus_addr,
  input  logic             i_bus_ready,
  input  cache_pkg::line_t i_bus_rdata
);

  import cache_pkg::*;

  localparam int LINES = 1 << `CACHE_IDX_W;

  core_state_e      state_q, state_d;
  logic [LINES-1:0] valid_q;
  tag_t             tag_q [LINES];
  line_t            data_q [LINES];
  tag_t             req_tag, inval_tag;
  idx_t             req_idx, inval_idx;
  logic             hit, inval_hit, fill_done, fill_kill, kill_q, filled_q;

  assign inval_tag = i_inval_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign inval_idx = i_inval_addr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign inval_hit = i_inval && valid_q[inval_idx] && (tag_q[inval_idx] == inval_tag);

  // request latched when accepted
  always_ff @(posedge clk) begin
    if (state_q == CORE_IDLE && i_req) begin
      req_tag <= i_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
      req_idx <= i_addr[`CACHE_OFS_W +: `CACHE_IDX_W];
    end
  end

  assign hit        = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign o_ack      = (state_q == CORE_LOOKUP) && (hit || filled_q);
  assign o_rdata    = data_q[req_idx];
  assign o_busy     = state_q != CORE_IDLE;
  assign o_bus_req  = state_q == CORE_FILL;
  assign o_bus_addr = {req_tag, req_idx, {`CACHE_OFS_W{1'b0}}};

  assign fill_done = o_bus_req && i_bus_ready;
  // line still goes back to the requester, only its valid bit is lost
  assign fill_kill = kill_q || i_flush || (i_inval && inval_idx == req_idx);

  ////////////////////////////////////////////////////////////
  // FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      CORE_IDLE:   if (i_req) state_d = CORE_LOOKUP;
      CORE_LOOKUP: state_d = o_ack ? CORE_IDLE : CORE_FILL;
      CORE_FILL:   if (i_bus_ready) state_d = CORE_LOOKUP;
      default:     state_d = CORE_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= CORE_IDLE;
      kill_q   <= 1'b0;
      filled_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      kill_q   <= o_bus_req && !fill_done && fill_kill;
      filled_q <= fill_done;
    end
  end

  ////////////////////////////////////////////////////////////
  // arrays
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= '0;
    end else if (i_flush) begin
      valid_q <= '0;
    end else begin
      if (fill_done) valid_q[req_idx] <= !fill_kill;
      if (inval_hit) valid_q[inval_idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_done) begin
      tag_q[req_idx]  <= req_tag;
      data_q[req_idx] <= i_bus_rdata;
    end
  end

  a_ack_req: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_ack |-> i_req);

  // flush only reaches an idle core
  a_flush_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_flush |-> !o_busy);

endmodule

// File: design/cache_nocache.sv
// uncached access engine
// one bus transfer per access, peripheral reads and all stores

module cache_nocache (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_req,
  input  cache_pkg::addr_t  i_addr,
  input  logic              i_op,
  input  cache_pkg::size_t  i_bytes,
  input  cache_pkg::dword_t i_wdata,
  output logic              o_ack,
  output cache_pkg::dword_t o_rdata,
  output logic              o_bus_req,
  output logic              o_bus_op,
  output cache_pkg::addr_t  o_bus_addr,
  output cache_pkg::dword_t o_bus_wdata,
  output cache_pkg::size_t  o_bus_size,
  input  logic              i_bus_ready,
  input  cache_pkg::line_t  i_bus_rdata
);

  import cache_pkg::*;

  nc_state_e state_q;
  addr_t     addr_q;
  logic      op_q;
  size_t     size_q;
  dword_t    wdata_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= NC_IDLE;
    end else if (state_q == NC_IDLE) begin
      if (i_req) state_q <= NC_BUSY;
    end else if (i_bus_ready) begin
      state_q <= NC_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == NC_IDLE && i_req) begin
      addr_q  <= i_addr;
      op_q    <= i_op;
      size_q  <= i_bytes;
      wdata_q <= i_wdata;
    end
  end

  assign o_bus_req   = state_q == NC_BUSY;
  assign o_bus_op    = op_q;
  assign o_bus_addr  = addr_q;
  assign o_bus_wdata = wdata_q;
  assign o_bus_size  = size_q;

  // ack on the handshake itself
  assign o_ack   = o_bus_req && i_bus_ready;
  assign o_rdata = addr_q[3] ? i_bus_rdata[127:64] : i_bus_rdata[63:0];

endmodule

// File: design/cache_bus_arb.sv
// memory bus arbiter
// fixed priority dcache, uncached, icache; grant held until ready

module cache_bus_arb (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_dc_req,
  input  cache_pkg::addr_t  i_dc_addr,
  output logic              o_dc_ready,
  output cache_pkg::line_t  o_dc_rdata,
  input  logic              i_nc_req,
  input  logic              i_nc_op,
  input  cache_pkg::addr_t  i_nc_addr,
  input  cache_pkg::dword_t i_nc_wdata,
  input  cache_pkg::size_t  i_nc_size,
  output logic              o_nc_ready,
  output cache_pkg::line_t  o_nc_rdata,
  input  logic              i_ic_req,
  input  cache_pkg::addr_t  i_ic_addr,
  output logic              o_ic_ready,
  output cache_pkg::line_t  o_ic_rdata,
  output logic              o_bus_valid,
  output logic              o_bus_op,
  output cache_pkg::addr_t  o_bus_addr,
  output cache_pkg::dword_t o_bus_wdata,
  output cache_pkg::size_t  o_bus_size,
  output logic              o_bus_line,
  input  logic              i_bus_ready,
  input  cache_pkg::line_t  i_bus_rdata
);

  import cache_pkg::*;

  grant_e gnt_q, gnt;

  always_comb begin
    if (gnt_q != GNT_NONE) gnt = gnt_q;
    else if (i_dc_req) gnt = GNT_DCACHE;
    else if (i_nc_req) gnt = GNT_NOCACHE;
    else if (i_ic_req) gnt = GNT_ICACHE;
    else gnt = GNT_NONE;
  end

  // lock until handshake
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      gnt_q <= GNT_NONE;
    end else begin
      gnt_q <= (o_bus_valid && !i_bus_ready) ? gnt : GNT_NONE;
    end
  end

  assign o_bus_valid = gnt != GNT_NONE;
  assign o_bus_line  = (gnt == GNT_DCACHE) || (gnt == GNT_ICACHE);
  assign o_bus_op    = (gnt == GNT_NOCACHE) && i_nc_op;
  assign o_bus_wdata = (gnt == GNT_NOCACHE) ? i_nc_wdata : '0;
  assign o_bus_size  = (gnt == GNT_NOCACHE) ? i_nc_size : '0;

  always_comb begin
    case (gnt)
      GNT_DCACHE:  o_bus_addr = i_dc_addr;
      GNT_NOCACHE: o_bus_addr = i_nc_addr;
      GNT_ICACHE:  o_bus_addr = i_ic_addr;
      default:     o_bus_addr = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // responses go to the granted client only
  assign o_dc_ready = i_bus_ready && (gnt == GNT_DCACHE);
  assign o_nc_ready = i_bus_ready && (gnt == GNT_NOCACHE);
  assign o_ic_ready = i_bus_ready && (gnt == GNT_ICACHE);
  assign o_dc_rdata = (gnt == GNT_DCACHE) ? i_bus_rdata : '0;
  assign o_nc_rdata = (gnt == GNT_NOCACHE) ? i_bus_rdata : '0;
  assign o_ic_rdata = (gnt == GNT_ICACHE) ? i_bus_rdata : '0;

  a_bus_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_bus_valid && !i_bus_ready |=> o_bus_valid &&
      $stable({o_bus_op, o_bus_addr, o_bus_wdata, o_bus_size, o_bus_line}));

endmodule

// File: design/cache.sv
// memory-side front end
// router, instruction and data caches, uncached engine, bus arbiter

module cache (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_icache_req,
  input  cache_pkg::addr_t  i_icache_addr,
  output logic              o_icache_ack,
  output cache_pkg::inst_t  o_icache_rdata,
  input  logic              i_dcache_req,
  input  cache_pkg::addr_t  i_dcache_addr,
  input  logic              i_dcache_op,
  input  cache_pkg::size_t  i_dcache_bytes,
  input  cache_pkg::dword_t i_dcache_wdata,
  output logic              o_dcache_ack,
  output cache_pkg::dword_t o_dcache_rdata,
  input  logic              i_fencei_req,
  output logic              o_fencei_ack,
  output logic              o_bus_valid,
  output logic              o_bus_op,
  output cache_pkg::addr_t  o_bus_addr,
  output cache_pkg::dword_t o_bus_wdata,
  output cache_pkg::size_t  o_bus_size,
  output logic              o_bus_line,
  input  logic              i_bus_ready,
  input  cache_pkg::line_t  i_bus_rdata
);

  import cache_pkg::*;

  logic   ic_req, ic_ack, ic_busy, ic_bus_req, ic_bus_ready;
  addr_t  ic_addr, ic_bus_addr;
  line_t  ic_rdata, ic_bus_rdata;
  logic   dc_req, dc_ack, dc_busy, dc_bus_req, dc_bus_ready;
  addr_t  dc_addr, dc_bus_addr;
  line_t  dc_rdata, dc_bus_rdata;
  logic   nc_req, nc_op, nc_ack, nc_bus_req, nc_bus_op, nc_bus_ready;
  addr_t  nc_addr, nc_bus_addr;
  size_t  nc_bytes, nc_bus_size;
  dword_t nc_wdata, nc_rdata, nc_bus_wdata;
  line_t  nc_bus_rdata;
  logic   inval, flush;
  addr_t  inval_addr;

  ////////////////////////////////////////////////////////////
  // input side
  cache_route u_route (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_icache_req   (i_icache_req),
    .i_icache_addr  (i_icache_addr),
    .o_icache_ack   (o_icache_ack),
    .o_icache_rdata (o_icache_rdata),
    .i_dcache_req   (i_dcache_req),
    .i_dcache_addr  (i_dcache_addr),
    .i_dcache_op    (i_dcache_op),
    .i_dcache_bytes (i_dcache_bytes),
    .i_dcache_wdata (i_dcache_wdata),
    .o_dcache_ack   (o_dcache_ack),
    .o_dcache_rdata (o_dcache_rdata),
    .i_fencei_req   (i_fencei_req),
    .o_fencei_ack   (o_fencei_ack),
    .o_ic_req       (ic_req),
    .o_ic_addr      (ic_addr),
    .i_ic_ack       (ic_ack),
    .i_ic_rdata     (ic_rdata),
    .i_ic_busy      (ic_busy),
    .o_dc_req       (dc_req),
    .o_dc_addr      (dc_addr),
    .i_dc_ack       (dc_ack),
    .i_dc_rdata     (dc_rdata),
    .i_dc_busy      (dc_busy),
    .o_nc_req       (nc_req),
    .o_nc_addr      (nc_addr),
    .o_nc_op        (nc_op),
    .o_nc_bytes     (nc_bytes),
    .o_nc_wdata     (nc_wdata),
    .i_nc_ack       (nc_ack),
    .i_nc_rdata     (nc_rdata),
    .o_inval        (inval),
    .o_inval_addr   (inval_addr),
    .o_flush        (flush)
  );

  cache_core u_icache (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req        (ic_req),
    .i_addr       (ic_addr),
    .o_ack        (ic_ack),
    .o_rdata      (ic_rdata),
    .o_busy       (ic_busy),
    .i_inval      (inval),
    .i_inval_addr (inval_addr),
    .i_flush      (flush),
    .o_bus_req    (ic_bus_req),
    .o_bus_addr   (ic_bus_addr),
    .i_bus_ready  (ic_bus_ready),
    .i_bus_rdata  (ic_bus_rdata)
  );

  cache_core u_dcache (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req        (dc_req),
    .i_addr       (dc_addr),
    .o_ack        (dc_ack),
    .o_rdata      (dc_rdata),
    .o_busy       (dc_busy),
    .i_inval      (inval),
    .i_inval_addr (inval_addr),
    .i_flush      (flush),
    .o_bus_req    (dc_bus_req),
    .o_bus_addr   (dc_bus_addr),
    .i_bus_ready  (dc_bus_ready),
    .i_bus_rdata  (dc_bus_rdata)
  );

  cache_nocache u_nocache (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_req       (nc_req),
    .i_addr      (nc_addr),
    .i_op        (nc_op),
    .i_bytes     (nc_bytes),
    .i_wdata     (nc_wdata),
    .o_ack       (nc_ack),
    .o_rdata     (nc_rdata),
    .o_bus_req   (nc_bus_req),
    .o_bus_op    (nc_bus_op),
    .o_bus_addr  (nc_bus_addr),
    .o_bus_wdata (nc_bus_wdata),
    .o_bus_size  (nc_bus_size),
    .i_bus_ready (nc_bus_ready),
    .i_bus_rdata (nc_bus_rdata)
  );

  ////////////////////////////////////////////////////////////
  // output side
  cache_bus_arb u_bus_arb (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_dc_req    (dc_bus_req),
    .i_dc_addr   (dc_bus_addr),
    .o_dc_ready  (dc_bus_ready),
    .o_dc_rdata  (dc_bus_rdata),
    .i_nc_req    (nc_bus_req),
    .i_nc_op     (nc_bus_op),
    .i_nc_addr   (nc_bus_addr),
    .i_nc_wdata  (nc_bus_wdata),
    .i_nc_size   (nc_bus_size),
    .o_nc_ready  (nc_bus_ready),
    .o_nc_rdata  (nc_bus_rdata),
    .i_ic_req    (ic_bus_req),
    .i_ic_addr   (ic_bus_addr),
    .o_ic_ready  (ic_bus_ready),
    .o_ic_rdata  (ic_bus_rdata),
    .o_bus_valid (o_bus_valid),
    .o_bus_op    (o_bus_op),
    .o_bus_addr  (o_bus_addr),
    .o_bus_wdata (o_bus_wdata),
    .o_bus_size  (o_bus_size),
    .o_bus_line  (o_bus_line),
    .i_bus_ready (i_bus_ready),
    .i_bus_rdata (i_bus_rdata)
  );

endmodule

// File: verif/tb_clock.sv
// testbench clock source
// free-running clock, 20 ns period

module tb_clock (
  output logic o_clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial o_clk = 1'b0;

  always #10 o_clk = ~o_clk;

endmodule

// File: verif/tb_cache.sv
// testbench for the cache front end
// replays access patterns against a sparse memory model with random bus delays

module tb_cache;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int FIELDS  = 6;
  localparam int MAX_PAT = 64;

  logic   clk;
  logic   i_arst_n;
  logic   i_icache_req, i_dcache_req, i_dcache_op, i_fencei_req;
  addr_t  i_icache_addr, i_dcache_addr;
  size_t  i_dcache_bytes;
  dword_t i_dcache_wdata;
  logic   o_icache_ack, o_dcache_ack, o_fencei_ack;
  inst_t  o_icache_rdata;
  dword_t o_dcache_rdata;
  logic   o_bus_valid, o_bus_op, o_bus_line;
  addr_t  o_bus_addr;
  dword_t o_bus_wdata;
  size_t  o_bus_size;
  logic   i_bus_ready = 1'b0;
  line_t  i_bus_rdata = '0;

  // kind, address, write data, size, expected data, expected line reads
  logic [63:0] pat [FIELDS*MAX_PAT];
  dword_t      mem_model [addr_t];
  int          num_pat;
  int          wait_cnt = -1;
  int          fetch_reads, data_reads, stores_seen;
  logic        fetch_pending;
  addr_t       fetch_line;
  addr_t       st_addr;
  dword_t      st_wdata;
  size_t       st_size;

  tb_clock u_clock (.o_clk(clk));

  cache u_cache (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_icache_req   (i_icache_req),
    .i_icache_addr  (i_icache_addr),
    .o_icache_ack   (o_icache_ack),
    .o_icache_rdata (o_icache_rdata),
    .i_dcache_req   (i_dcache_req),
    .i_dcache_addr  (i_dcache_addr),
    .i_dcache_op    (i_dcache_op),
    .i_dcache_bytes (i_dcache_bytes),
    .i_dcache_wdata (i_dcache_wdata),
    .o_dcache_ack   (o_dcache_ack),
    .o_dcache_rdata (o_dcache_rdata),
    .i_fencei_req   (i_fencei_req),
    .o_fencei_ack   (o_fencei_ack),
    .o_bus_valid    (o_bus_valid),
    .o_bus_op       (o_bus_op),
    .o_bus_addr     (o_bus_addr),
    .o_bus_wdata    (o_bus_wdata),
    .o_bus_size     (o_bus_size),
    .o_bus_line     (o_bus_line),
    .i_bus_ready    (i_bus_ready),
    .i_bus_rdata    (i_bus_rdata)
  );

  task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model

  function automatic dword_t dword_at(addr_t a);
    addr_t da;
    da = {a[31:3], 3'b000};
    if (mem_model.exists(da)) return mem_model[da];
    // unwritten: own address on top, inverted below
    return {da, ~da};
  endfunction

  function automatic line_t line_at(addr_t a);
    addr_t base;
    base = {a[31:4], 4'h0};
    return {dword_at(base + 32'd8), dword_at(base)};
  endfunction

  function automatic dword_t size_mask(size_t size);
    dword_t m;
    m = '0;
    for (int i = 0; i <= int'(size); i++) m[8*i +: 8] = 8'hff;
    return m;
  endfunction

  task automatic merge_store(addr_t a, dword_t wdata, size_t size);
    addr_t  ba;
    dword_t d;
    for (int i = 0; i <= int'(size); i++) begin
      ba = a + addr_t'(i);
      d  = dword_at(ba);
      d[8*ba[2:0] +: 8] = wdata[8*i +: 8];
      mem_model[{ba[31:3], 3'b000}] = d;
    end
  endtask

  // bus responder, ready after 0 to 3 idle cycles
  always @(negedge clk) begin
    if (!i_arst_n || i_bus_ready) begin
      i_bus_ready = 1'b0;
      wait_cnt    = -1;
    end else if (o_bus_valid) begin
      if (wait_cnt < 0) wait_cnt = int'($urandom % 4);
      if (wait_cnt == 0) begin
        i_bus_rdata = line_at(o_bus_addr);
        i_bus_ready = 1'b1;
      end else begin
        wait_cnt--;
      end
    end
  end

  // completed transfers, line reads credited to the fetch when its line matches
  always @(posedge clk) begin
    if (i_arst_n && o_bus_valid && i_bus_ready) begin
      if (o_bus_op) begin
        stores_seen++;
        check_value("o_bus_addr", 64'(o_bus_addr), 64'(st_addr));
        check_value("o_bus_size", 64'(o_bus_size), 64'(st_size));
        check_value("o_bus_wdata", o_bus_wdata & size_mask(st_size),
                    st_wdata & size_mask(st_size));
        merge_store(o_bus_addr, o_bus_wdata, o_bus_size);
      end else if (o_bus_line) begin
        if (fetch_pending && {o_bus_addr[31:4], 4'h0} == fetch_line) fetch_reads++;
        else data_reads++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pipeline side accesses, driven on the falling edge

  task automatic fetch_word(int p);
    inst_t got;
    i_icache_addr = pat[FIELDS*p+1][31:0];
    i_icache_req  = 1'b1;
    fetch_line    = {i_icache_addr[31:4], 4'h0};
    fetch_pending = 1'b1;
    @(posedge clk);
    while (!o_icache_ack) @(posedge clk);
    got = o_icache_rdata;
    @(negedge clk);
    i_icache_req  = 1'b0;
    fetch_pending = 1'b0;
    check_value("o_icache_rdata", {32'h0, got}, pat[FIELDS*p+4]);
  endtask

  task automatic load_dword(int p);
    dword_t got;
    i_dcache_addr  = pat[FIELDS*p+1][31:0];
    i_dcache_op    = 1'b0;
    i_dcache_bytes = pat[FIELDS*p+3][2:0];
    i_dcache_wdata = '0;
    i_dcache_req   = 1'b1;
    @(posedge clk);
    while (!o_dcache_ack) @(posedge clk);
    got = o_dcache_rdata;
    @(negedge clk);
    i_dcache_req = 1'b0;
    check_value("o_dcache_rdata", got, pat[FIELDS*p+4]);
  endtask

  task automatic store_dword(int p);
    st_addr        = pat[FIELDS*p+1][31:0];
    st_wdata       = pat[FIELDS*p+2];
    st_size        = pat[FIELDS*p+3][2:0];
    i_dcache_addr  = st_addr;
    i_dcache_op    = 1'b1;
    i_dcache_bytes = st_size;
    i_dcache_wdata = st_wdata;
    i_dcache_req   = 1'b1;
    @(posedge clk);
    while (!o_dcache_ack) @(posedge clk);
    @(negedge clk);
    i_dcache_req = 1'b0;
    i_dcache_op  = 1'b0;
  endtask

  task automatic request_fence();
    i_fencei_req = 1'b1;
    @(posedge clk);
    while (!o_fencei_ack) @(posedge clk);
    @(negedge clk);
    i_fencei_req = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int          f0, d0, s0, p;
    logic [63:0] kind;
    void'($urandom(91818));
    i_arst_n       = 1'b0;
    i_icache_req   = 1'b0;
    i_icache_addr  = '0;
    i_dcache_req   = 1'b0;
    i_dcache_addr  = '0;
    i_dcache_op    = 1'b0;
    i_dcache_bytes = '0;
    i_dcache_wdata = '0;
    i_fencei_req   = 1'b0;
    fetch_pending  = 1'b0;
    fetch_line     = '0;
    for (int k = 0; k < FIELDS*MAX_PAT; k++) pat[k] = '1;
    $readmemh("verif/cache_patterns.txt", pat);
    num_pat = 0;
    while (num_pat < MAX_PAT && pat[FIELDS*num_pat] != '1) num_pat++;
    if (num_pat == 0) begin
      $display("no access patterns could be read from the pattern file");
      $display("Simulation finished: FAIL");
      $fatal(1);
    end

    repeat (10) @(negedge clk);
    i_arst_n = 1'b1;
    @(posedge clk);
    check_value("o_icache_ack", 64'(o_icache_ack), 64'd0);
    check_value("o_dcache_ack", 64'(o_dcache_ack), 64'd0);
    check_value("o_fencei_ack", 64'(o_fencei_ack), 64'd0);
    check_value("o_bus_valid", 64'(o_bus_valid), 64'd0);
    @(negedge clk);

    p = 0;
    while (p < num_pat) begin
      f0   = fetch_reads;
      d0   = data_reads;
      s0   = stores_seen;
      kind = pat[FIELDS*p];
      case (kind)
        64'd0: begin
          fetch_word(p);
          check_value("fetch line reads", 64'(fetch_reads - f0), pat[FIELDS*p+5]);
          check_value("load line reads", 64'(data_reads - d0), 64'd0);
          p++;
        end
        64'd1: begin
          load_dword(p);
          check_value("load line reads", 64'(data_reads - d0), pat[FIELDS*p+5]);
          check_value("fetch line reads", 64'(fetch_reads - f0), 64'd0);
          p++;
        end
        64'd2: begin
          store_dword(p);
          check_value("bus store count", 64'(stores_seen - s0), 64'd1);
          check_value("load line reads", 64'(data_reads - d0), pat[FIELDS*p+5]);
          p++;
        end
        64'd3: begin
          request_fence();
          check_value("line reads", 64'(fetch_reads + data_reads - f0 - d0),
                      pat[FIELDS*p+5]);
          p++;
        end
        64'd4: begin
          if (p + 1 >= num_pat || pat[FIELDS*(p+1)] != 64'd1) begin
            $display("pattern %0d is a paired fetch without a load after it", p);
            $display("Simulation finished: FAIL");
            $fatal(1);
          end
          // both channels start on the same edge
          fork
            fetch_word(p);
            load_dword(p + 1);
          join
          check_value("fetch line reads", 64'(fetch_reads - f0), pat[FIELDS*p+5]);
          check_value("load line reads", 64'(data_reads - d0), pat[FIELDS*(p+1)+5]);
          p += 2;
        end
        default: begin
          $display("pattern %0d has an unknown access kind %0h", p, kind);
          $display("Simulation finished: FAIL");
          $fatal(1);
        end
      endcase
    end

    $display("Simulation finished: PASS");
    $finish;
  end

  // watchdog
  initial begin
    wait (num_pat > 0);
    repeat (num_pat * 60 + 20) @(posedge clk);
    $display("timeout: accesses still pending after %0d cycles", num_pat * 60 + 20);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

endmodule

// File: verif/cache_patterns.txt
// kind addr wdata size rdata reads (size is byte count minus one, reads is line reads)
// kind 0 fetch, 1 load, 2 store, 3 fence.i, 4 fetch issued together with the next load
0 80000010 0000000000000000 0 000000007FFFFFEF 1
0 80000014 0000000000000000 0 0000000080000010 0
1 80000018 0000000000000000 7 800000187FFFFFE7 1
1 80000010 0000000000000000 7 800000107FFFFFEF 0
1 30000120 0000000000000000 7 30000120CFFFFEDF 1
0 3000012C 0000000000000000 0 0000000030000128 1
1 80000110 0000000000000000 7 800001107FFFFEEF 1
1 80000010 0000000000000000 7 800000107FFFFFEF 1
1 10000008 0000000000000000 7 10000008EFFFFFF7 0
0 20000004 0000000000000000 0 0000000020000000 0
1 40000000 0000000000000000 7 40000000BFFFFFFF 0
0 00000100 0000000000000000 0 00000000FFFFFEFF 0
2 80000010 1122334455667788 3 0000000000000000 0
1 80000010 0000000000000000 7 8000001055667788 1
0 80000010 0000000000000000 0 0000000055667788 1
0 80000014 0000000000000000 0 0000000080000010 0
2 80000016 000000000000ABCD 1 0000000000000000 0
0 80000014 0000000000000000 0 00000000ABCD0010 1
2 10000008 0123456789ABCDEF 7 0000000000000000 0
1 10000008 0000000000000000 7 0123456789ABCDEF 0
3 00000000 0000000000000000 0 0000000000000000 0
1 30000120 0000000000000000 7 30000120CFFFFEDF 1
0 3000012C 0000000000000000 0 0000000030000128 1
1 80000018 0000000000000000 7 800000187FFFFFE7 1
4 30000204 0000000000000000 0 0000000030000200 1
1 80000230 0000000000000000 7 800002307FFFFDCF 1
4 10000010 0000000000000000 0 00000000EFFFFFEF 0
1 30000208 0000000000000000 7 30000208CFFFFDF7 1
4 80000234 0000000000000000 0 0000000080000230 1
1 20000018 0000000000000000 7 20000018DFFFFFE7 0

// File: sources.f
+incdir+design
design/cache_pkg.sv
design/cache_route.sv
design/cache_core.sv
design/cache_nocache.sv
design/cache_bus_arb.sv
design/cache.sv
verif/tb_clock.sv
verif/tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module tb_cache -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cache > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

exit 0
